// File: mipsDefs_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// datapath and address width
`define XLEN 32

// register file index width
`define REG_AW 5

// first fetch address out of reset, in kseg1
`define RESET_PC 32'hbfc00000

// kseg0/kseg1 fold onto the same physical range
`define PHYS_MASK 32'h1fffffff

// jal writes its return address here
`define LINK_REG 5'd31

`endif

// File: mipsPkg.sv
`include "mipsDefs_defs.svh"

package mipsPkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} aluOpE;

	typedef enum logic [2:0] {
		MEM_NONE,
		MEM_LW,
		MEM_LB,
		MEM_LBU,
		MEM_SW,
		MEM_SB
	} memOpE;

	typedef enum logic [2:0] {
		CTL_NONE,
		CTL_BEQ,
		CTL_BNE,
		CTL_J,
		CTL_JAL,
		CTL_JR
	} ctrlKindE;

	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_MEM,
		FWD_WB
	} fwdSelE;

	typedef struct packed {
		logic             valid;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] instr;
	} ifIdT;

	typedef struct packed {
		logic               valid;
		logic [`XLEN-1:0]   pc;
		logic [`REG_AW-1:0] rs;     // zero when the instruction does not read rs
		logic [`REG_AW-1:0] rt;
		logic [`XLEN-1:0]   rsVal;
		logic [`XLEN-1:0]   rtVal;
		logic [`XLEN-1:0]   imm;    // holds shamt for sll and srl
		logic               useImm;
		aluOpE              aluOp;
		memOpE              memOp;
		logic               regWrite;
		logic [`REG_AW-1:0] dest;
		ctrlKindE           ctrlKind;
		logic [`XLEN-1:0]   target;
	} idExT;

	typedef struct packed {
		logic               valid;
		logic [`XLEN-1:0]   pc;
		logic [`XLEN-1:0]   aluRes;
		logic [`XLEN-1:0]   storeData;
		logic [3:0]         byteEn;
		memOpE              memOp;
		logic               regWrite;
		logic [`REG_AW-1:0] dest;
	} exMemT;

	typedef struct packed {
		logic               valid;
		logic [`XLEN-1:0]   pc;
		logic [`XLEN-1:0]   result;
		memOpE              memOp;
		logic [1:0]         addrLo;
		logic               regWrite;
		logic [`REG_AW-1:0] dest;
	} memWbT;

	typedef struct packed {
		logic               we;
		logic [`REG_AW-1:0] dest;
		logic [`XLEN-1:0]   data;
	} wbBusT;

	typedef struct packed {
		logic             taken;
		logic [`XLEN-1:0] target;
	} redirectT;

endpackage

// File: fetchStage.sv
`timescale 1ns/100ps
`include "mipsDefs_defs.svh"

module fetchStage (
	input  logic              clk,
	input  logic              rstN_i,
	input  logic              stall_i,
	input  logic              flush_i,
	input  mipsPkg::redirectT redirect_i,
	output logic [`XLEN-1:0]  instAddr_o,
	input  logic [`XLEN-1:0]  instRdata_i,
	output mipsPkg::ifIdT     ifId_o
);

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] pcNext;
	logic [`XLEN-1:0] pcD; // pc of the word the SRAM returns this cycle
	logic             validD;
	logic             heldQ;
	logic [`XLEN-1:0] instrHold;

	always_comb begin
		if (redirect_i.taken) begin
			pcNext = redirect_i.target;
		end else if (stall_i) begin
			pcNext = pc; // same address again so the SRAM re-reads it
		end else begin
			pcNext = pc + `XLEN'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			pc <= `RESET_PC;
			validD <= 1'b0;
			heldQ <= 1'b0;
		end else begin
			pc <= pcNext;
			heldQ <= stall_i;
			if (flush_i) begin
				validD <= 1'b0;
				pcD <= pc;
			end else if (!stall_i) begin
				validD <= 1'b1;
				pcD <= pc;
			end
		end
	end

	// the SRAM output moves on during a stall, so fetch keeps a copy for decode
	always_ff @(posedge clk) begin
		if (stall_i) begin
			instrHold <= ifId_o.instr;
		end
	end

	assign instAddr_o = pc & `PHYS_MASK;

	always_comb begin
		ifId_o.valid = validD;
		ifId_o.pc = pcD;
		ifId_o.instr = heldQ ? instrHold : instRdata_i;
	end

endmodule

// File: decodeStage.sv
`timescale 1ns/100ps
`include "mipsDefs_defs.svh"

module decodeStage (
	input  logic                clk,
	input  logic                rstN_i,
	input  logic                stall_i,
	input  logic                bubble_i,
	input  mipsPkg::ifIdT       ifId_i,
	input  mipsPkg::wbBusT      wb_i,
	output mipsPkg::idExT       idEx_o,
	output logic [`REG_AW-1:0]  rsIdx_o,
	output logic [`REG_AW-1:0]  rtIdx_o,
	output logic                valid_o
);

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LB      = 6'h20,
		OP_LW      = 6'h23,
		OP_LBU     = 6'h24,
		OP_SB      = 6'h28,
		OP_SW      = 6'h2b
	} opE;

	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} functE;

	logic [`XLEN-1:0]   regs [32];
	logic [`XLEN-1:0]   instr;
	logic [`XLEN-1:0]   pcPlus4;
	logic [15:0]        imm16;
	logic [`REG_AW-1:0] rs;
	logic [`REG_AW-1:0] rt;
	opE                 op;
	functE              funct;
	mipsPkg::aluOpE     aluOp;
	mipsPkg::memOpE     memOp;
	mipsPkg::ctrlKindE  ctrlKind;
	logic               useImm;
	logic               zeroExt;
	logic               regWrite;
	logic               useRs;
	logic               useRt;
	logic [`REG_AW-1:0] dest;
	mipsPkg::idExT      idExNext;

	// a register written back this cycle is seen by the read in the same cycle
	function automatic logic [`XLEN-1:0] readReg(input logic [`REG_AW-1:0] idx);
		if (idx == '0) begin
			return '0;
		end else if (wb_i.we && wb_i.dest == idx) begin
			return wb_i.data;
		end
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (wb_i.we) begin
			regs[wb_i.dest] <= wb_i.data;
		end
	end

	assign instr = ifId_i.instr;
	assign op = opE'(instr[31:26]);
	assign funct = functE'(instr[5:0]);
	assign imm16 = instr[15:0];
	assign pcPlus4 = ifId_i.pc + `XLEN'd4;

	always_comb begin
		aluOp = mipsPkg::ALU_ADD;
		memOp = mipsPkg::MEM_NONE;
		ctrlKind = mipsPkg::CTL_NONE;
		useImm = 1'b1;
		zeroExt = 1'b0;
		regWrite = 1'b1;
		useRs = 1'b1;
		useRt = 1'b0;
		dest = instr[20:16];
		case (op)
			OP_SPECIAL: begin
				useImm = 1'b0;
				useRt = 1'b1;
				dest = instr[15:11];
				case (funct)
					FN_ADDU: aluOp = mipsPkg::ALU_ADD;
					FN_SUBU: aluOp = mipsPkg::ALU_SUB;
					FN_AND:  aluOp = mipsPkg::ALU_AND;
					FN_OR:   aluOp = mipsPkg::ALU_OR;
					FN_XOR:  aluOp = mipsPkg::ALU_XOR;
					FN_SLT:  aluOp = mipsPkg::ALU_SLT;
					FN_SLTU: aluOp = mipsPkg::ALU_SLTU;
					FN_SLL: begin
						aluOp = mipsPkg::ALU_SLL;
						useRs = 1'b0;
					end
					FN_SRL: begin
						aluOp = mipsPkg::ALU_SRL;
						useRs = 1'b0;
					end
					FN_JR: begin
						ctrlKind = mipsPkg::CTL_JR;
						regWrite = 1'b0;
						useRt = 1'b0;
					end
					default: regWrite = 1'b0;
				endcase
			end
			OP_ADDIU: aluOp = mipsPkg::ALU_ADD;
			OP_SLTI:  aluOp = mipsPkg::ALU_SLT;
			OP_ANDI: begin
				aluOp = mipsPkg::ALU_AND;
				zeroExt = 1'b1;
			end
			OP_ORI: begin
				aluOp = mipsPkg::ALU_OR;
				zeroExt = 1'b1;
			end
			OP_LUI: begin
				aluOp = mipsPkg::ALU_LUI;
				zeroExt = 1'b1;
				useRs = 1'b0;
			end
			OP_LW:  memOp = mipsPkg::MEM_LW;
			OP_LB:  memOp = mipsPkg::MEM_LB;
			OP_LBU: memOp = mipsPkg::MEM_LBU;
			OP_SW, OP_SB: begin
				memOp = (op == OP_SW) ? mipsPkg::MEM_SW : mipsPkg::MEM_SB;
				regWrite = 1'b0;
				useRt = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				ctrlKind = (op == OP_BEQ) ? mipsPkg::CTL_BEQ : mipsPkg::CTL_BNE;
				regWrite = 1'b0;
				useRt = 1'b1;
			end
			OP_J: begin
				ctrlKind = mipsPkg::CTL_J;
				regWrite = 1'b0;
				useRs = 1'b0;
			end
			OP_JAL: begin
				ctrlKind = mipsPkg::CTL_JAL;
				useRs = 1'b0;
				dest = `LINK_REG;
			end
			default: regWrite = 1'b0; // unknown opcodes retire as a nop
		endcase
	end

	assign rs = useRs ? instr[25:21] : '0;
	assign rt = useRt ? instr[20:16] : '0;

	always_comb begin
		idExNext.valid = ifId_i.valid;
		idExNext.pc = ifId_i.pc;
		idExNext.rs = rs;
		idExNext.rt = rt;
		idExNext.rsVal = readReg(rs);
		idExNext.rtVal = readReg(rt);
		if (aluOp == mipsPkg::ALU_SLL || aluOp == mipsPkg::ALU_SRL) begin
			idExNext.imm = {{(`XLEN-5){1'b0}}, instr[10:6]};
		end else if (zeroExt) begin
			idExNext.imm = {16'b0, imm16};
		end else begin
			idExNext.imm = {{16{imm16[15]}}, imm16};
		end
		idExNext.useImm = useImm;
		idExNext.aluOp = aluOp;
		idExNext.memOp = memOp;
		idExNext.regWrite = regWrite;
		idExNext.dest = dest;
		idExNext.ctrlKind = ctrlKind;
		if (ctrlKind == mipsPkg::CTL_J || ctrlKind == mipsPkg::CTL_JAL) begin
			idExNext.target = {pcPlus4[31:28], instr[25:0], 2'b00};
		end else begin
			idExNext.target = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN_i || bubble_i) begin
			idEx_o <= '0;
		end else if (!stall_i) begin
			idEx_o <= idExNext;
		end
	end

	assign rsIdx_o = rs;
	assign rtIdx_o = rt;
	assign valid_o = ifId_i.valid;

endmodule

// File: executeStage.sv
`timescale 1ns/100ps
`include "mipsDefs_defs.svh"

module executeStage (
	input  logic              clk,
	input  logic              rstN_i,
	input  mipsPkg::idExT     idEx_i,
	input  mipsPkg::fwdSelE   fwdA_i,
	input  mipsPkg::fwdSelE   fwdB_i,
	input  logic [`XLEN-1:0]  memFwd_i,
	input  mipsPkg::wbBusT    wb_i,
	output mipsPkg::redirectT redirect_o,
	output mipsPkg::exMemT    exMem_o
);

	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] rtFwd;
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] aluRes;
	logic             branchHit;
	mipsPkg::exMemT   exMemNext;

	function automatic logic [`XLEN-1:0] pickOperand(input mipsPkg::fwdSelE sel,
			input logic [`XLEN-1:0] regVal, input logic [`XLEN-1:0] memVal,
			input logic [`XLEN-1:0] wbVal);
		case (sel)
			mipsPkg::FWD_MEM: return memVal;
			mipsPkg::FWD_WB:  return wbVal;
			default:          return regVal;
		endcase
	endfunction

	assign opA = pickOperand(fwdA_i, idEx_i.rsVal, memFwd_i, wb_i.data);
	assign rtFwd = pickOperand(fwdB_i, idEx_i.rtVal, memFwd_i, wb_i.data);
	assign opB = idEx_i.useImm ? idEx_i.imm : rtFwd;

	always_comb begin
		case (idEx_i.aluOp)
			mipsPkg::ALU_SUB:  aluRes = opA - opB;
			mipsPkg::ALU_AND:  aluRes = opA & opB;
			mipsPkg::ALU_OR:   aluRes = opA | opB;
			mipsPkg::ALU_XOR:  aluRes = opA ^ opB;
			mipsPkg::ALU_SLT:  aluRes = {31'b0, $signed(opA) < $signed(opB)};
			mipsPkg::ALU_SLTU: aluRes = {31'b0, opA < opB};
			mipsPkg::ALU_SLL:  aluRes = opB << idEx_i.imm[4:0];
			mipsPkg::ALU_SRL:  aluRes = opB >> idEx_i.imm[4:0];
			mipsPkg::ALU_LUI:  aluRes = {opB[15:0], 16'b0};
			default:           aluRes = opA + opB;
		endcase
		if (idEx_i.ctrlKind == mipsPkg::CTL_JAL) begin
			aluRes = idEx_i.pc + `XLEN'd8; // return address skips the delay slot
		end
	end

	always_comb begin
		case (idEx_i.ctrlKind)
			mipsPkg::CTL_BEQ: branchHit = (opA == rtFwd);
			mipsPkg::CTL_BNE: branchHit = (opA != rtFwd);
			mipsPkg::CTL_J, mipsPkg::CTL_JAL, mipsPkg::CTL_JR: branchHit = 1'b1;
			default: branchHit = 1'b0;
		endcase
	end

	assign redirect_o.taken = idEx_i.valid && branchHit;
	assign redirect_o.target = (idEx_i.ctrlKind == mipsPkg::CTL_JR) ? opA : idEx_i.target;

	always_comb begin
		exMemNext.valid = idEx_i.valid;
		exMemNext.pc = idEx_i.pc;
		exMemNext.aluRes = aluRes;
		exMemNext.memOp = idEx_i.memOp;
		exMemNext.regWrite = idEx_i.regWrite;
		exMemNext.dest = idEx_i.dest;
		case (idEx_i.memOp)
			mipsPkg::MEM_SW: begin
				exMemNext.storeData = rtFwd;
				exMemNext.byteEn = 4'b1111;
			end
			mipsPkg::MEM_SB: begin
				exMemNext.storeData = {4{rtFwd[7:0]}}; // byte copied to every lane
				exMemNext.byteEn = 4'b0001 << aluRes[1:0];
			end
			default: begin
				exMemNext.storeData = rtFwd;
				exMemNext.byteEn = 4'b0000;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			exMem_o.valid <= 1'b0;
			exMem_o.regWrite <= 1'b0;
			exMem_o.byteEn <= 4'b0000;
			exMem_o.memOp <= mipsPkg::MEM_NONE;
		end else begin
			exMem_o <= exMemNext;
		end
	end

endmodule

// File: memoryStage.sv
`timescale 1ns/100ps
`include "mipsDefs_defs.svh"

module memoryStage (
	input  logic             clk,
	input  logic             rstN_i,
	input  mipsPkg::exMemT   exMem_i,
	output logic [`XLEN-1:0] dataAddr_o,
	output logic [3:0]       dataWen_o,
	output logic [`XLEN-1:0] dataWdata_o,
	input  logic [`XLEN-1:0] dataRdata_i,
	output logic [`XLEN-1:0] memFwd_o,
	output mipsPkg::wbBusT   wb_o,
	output logic [`XLEN-1:0] debugPc_o
);

	mipsPkg::memWbT   memWbQ;
	logic [7:0]       loadByte;
	logic [`XLEN-1:0] wbData;

	assign dataAddr_o = exMem_i.aluRes & `PHYS_MASK;
	assign dataWen_o = exMem_i.valid ? exMem_i.byteEn : 4'b0000;
	assign dataWdata_o = exMem_i.storeData;
	assign memFwd_o = exMem_i.aluRes;

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			memWbQ.valid <= 1'b0;
			memWbQ.regWrite <= 1'b0;
			memWbQ.memOp <= mipsPkg::MEM_NONE;
		end else begin
			memWbQ.valid <= exMem_i.valid;
			memWbQ.pc <= exMem_i.pc;
			memWbQ.result <= exMem_i.aluRes;
			memWbQ.memOp <= exMem_i.memOp;
			memWbQ.addrLo <= exMem_i.aluRes[1:0];
			memWbQ.regWrite <= exMem_i.regWrite;
			memWbQ.dest <= exMem_i.dest;
		end
	end

	// the SRAM answers in this cycle for the address registered above
	assign loadByte = dataRdata_i[{memWbQ.addrLo, 3'b000} +: 8];

	always_comb begin
		case (memWbQ.memOp)
			mipsPkg::MEM_LW:  wbData = dataRdata_i;
			mipsPkg::MEM_LB:  wbData = {{24{loadByte[7]}}, loadByte};
			mipsPkg::MEM_LBU: wbData = {24'b0, loadByte};
			default:          wbData = memWbQ.result;
		endcase
	end

	assign wb_o.we = memWbQ.valid && memWbQ.regWrite && (memWbQ.dest != '0);
	assign wb_o.dest = memWbQ.dest;
	assign wb_o.data = wbData;
	assign debugPc_o = memWbQ.pc;

endmodule

// File: hazardCtrl.sv
`timescale 1ns/100ps
`include "mipsDefs_defs.svh"

module hazardCtrl (
	input  logic [`REG_AW-1:0] rsD_i,
	input  logic [`REG_AW-1:0] rtD_i,
	input  logic               validD_i,
	input  mipsPkg::idExT      idEx_i,
	input  mipsPkg::exMemT     exMem_i,
	input  mipsPkg::wbBusT     wb_i,
	input  mipsPkg::redirectT  redirect_i,
	output logic               stallFD_o,
	output logic               bubbleE_o,
	output logic               flushD_o,
	output mipsPkg::fwdSelE    fwdA_o,
	output mipsPkg::fwdSelE    fwdB_o
);

	logic loadInE;
	logic loadUse;

	// memory stage wins since it holds the younger result
	function automatic mipsPkg::fwdSelE pickSource(input logic [`REG_AW-1:0] src,
			input mipsPkg::exMemT memRec, input mipsPkg::wbBusT wbRec);
		if (src == '0) begin
			return mipsPkg::FWD_NONE;
		end else if (memRec.valid && memRec.regWrite && memRec.dest == src) begin
			return mipsPkg::FWD_MEM;
		end else if (wbRec.we && wbRec.dest == src) begin
			return mipsPkg::FWD_WB;
		end
		return mipsPkg::FWD_NONE;
	endfunction

	assign loadInE = idEx_i.valid && idEx_i.regWrite && (idEx_i.dest != '0)
		&& (idEx_i.memOp == mipsPkg::MEM_LW || idEx_i.memOp == mipsPkg::MEM_LB
		|| idEx_i.memOp == mipsPkg::MEM_LBU);

	// load data is only ready in writeback and so comes one cycle too late for execute
	assign loadUse = validD_i && loadInE
		&& (idEx_i.dest == rsD_i || idEx_i.dest == rtD_i);

	assign stallFD_o = loadUse;
	assign bubbleE_o = loadUse;
	assign flushD_o = redirect_i.taken; // delay slot is already in decode and survives

	assign fwdA_o = pickSource(idEx_i.rs, exMem_i, wb_i);
	assign fwdB_o = pickSource(idEx_i.rt, exMem_i, wb_i);

endmodule

// File: mipsCore.sv
`timescale 1ns/100ps
`include "mipsDefs_defs.svh"

module mipsCore (
	input  logic               clk,
	input  logic               rstN_i,
	output logic [`XLEN-1:0]   instAddr_o,
	input  logic [`XLEN-1:0]   instRdata_i,
	output logic [`XLEN-1:0]   dataAddr_o,
	output logic [3:0]         dataWen_o,
	output logic [`XLEN-1:0]   dataWdata_o,
	input  logic [`XLEN-1:0]   dataRdata_i,
	output logic [`XLEN-1:0]   debugWbPc_o,
	output logic [3:0]         debugWbRfWen_o,
	output logic [`REG_AW-1:0] debugWbRfWnum_o,
	output logic [`XLEN-1:0]   debugWbRfWdata_o
);

	mipsPkg::ifIdT      ifId;
	mipsPkg::idExT      idEx;
	mipsPkg::exMemT     exMem;
	mipsPkg::wbBusT     wbBus;
	mipsPkg::redirectT  redirect;
	mipsPkg::fwdSelE    fwdA;
	mipsPkg::fwdSelE    fwdB;
	logic               stallFD;
	logic               bubbleE;
	logic               flushD;
	logic [`REG_AW-1:0] rsD;
	logic [`REG_AW-1:0] rtD;
	logic               validD;
	logic [`XLEN-1:0]   memFwd;

	fetchStage u_fetchStage (
		.clk         (clk),
		.rstN_i      (rstN_i),
		.stall_i     (stallFD),
		.flush_i     (flushD),
		.redirect_i  (redirect),
		.instAddr_o  (instAddr_o),
		.instRdata_i (instRdata_i),
		.ifId_o      (ifId)
	);

	decodeStage u_decodeStage (
		.clk      (clk),
		.rstN_i   (rstN_i),
		.stall_i  (stallFD),
		.bubble_i (bubbleE),
		.ifId_i   (ifId),
		.wb_i     (wbBus),
		.idEx_o   (idEx),
		.rsIdx_o  (rsD),
		.rtIdx_o  (rtD),
		.valid_o  (validD)
	);

	executeStage u_executeStage (
		.clk        (clk),
		.rstN_i     (rstN_i),
		.idEx_i     (idEx),
		.fwdA_i     (fwdA),
		.fwdB_i     (fwdB),
		.memFwd_i   (memFwd),
		.wb_i       (wbBus),
		.redirect_o (redirect),
		.exMem_o    (exMem)
	);

	memoryStage u_memoryStage (
		.clk         (clk),
		.rstN_i      (rstN_i),
		.exMem_i     (exMem),
		.dataAddr_o  (dataAddr_o),
		.dataWen_o   (dataWen_o),
		.dataWdata_o (dataWdata_o),
		.dataRdata_i (dataRdata_i),
		.memFwd_o    (memFwd),
		.wb_o        (wbBus),
		.debugPc_o   (debugWbPc_o)
	);

	hazardCtrl u_hazardCtrl (
		.rsD_i      (rsD),
		.rtD_i      (rtD),
		.validD_i   (validD),
		.idEx_i     (idEx),
		.exMem_i    (exMem),
		.wb_i       (wbBus),
		.redirect_i (redirect),
		.stallFD_o  (stallFD),
		.bubbleE_o  (bubbleE),
		.flushD_o   (flushD),
		.fwdA_o     (fwdA),
		.fwdB_o     (fwdB)
	);

	assign debugWbRfWen_o = {4{wbBus.we}};
	assign debugWbRfWnum_o = wbBus.dest;
	assign debugWbRfWdata_o = wbBus.data;

endmodule

// File: tbMipsCore.sv
`timescale 1ns/100ps
`include "mipsDefs_defs.svh"

module tbMipsCore;

	logic               clk;
	logic               rstN;
	logic [`XLEN-1:0]   instAddr;
	logic [`XLEN-1:0]   instRdata;
	logic [`XLEN-1:0]   dataAddr;
	logic [3:0]         dataWen;
	logic [`XLEN-1:0]   dataWdata;
	logic [`XLEN-1:0]   dataRdata;
	logic [`XLEN-1:0]   wbPc;
	logic [3:0]         wbRfWen;
	logic [`REG_AW-1:0] wbRfWnum;
	logic [`XLEN-1:0]   wbRfWdata;

	logic [`XLEN-1:0]   rom [64];
	logic [`XLEN-1:0]   ram [64];
	logic [`XLEN-1:0]   instAddrQ;
	logic [`XLEN-1:0]   dataAddrQ;
	logic [`XLEN-1:0]   dataWdataQ;
	logic [3:0]         dataWenQ;

	mipsPkg::wbBusT     expWb[$];
	logic [`XLEN-1:0]   expPc[$];
	logic [`XLEN-1:0]   chkAddr[$];
	logic [`XLEN-1:0]   chkData[$];
	int                 wbIdx;

	mipsCore u_mipsCore (
		.clk              (clk),
		.rstN_i           (rstN),
		.instAddr_o       (instAddr),
		.instRdata_i      (instRdata),
		.dataAddr_o       (dataAddr),
		.dataWen_o        (dataWen),
		.dataWdata_o      (dataWdata),
		.dataRdata_i      (dataRdata),
		.debugWbPc_o      (wbPc),
		.debugWbRfWen_o   (wbRfWen),
		.debugWbRfWnum_o  (wbRfWnum),
		.debugWbRfWdata_o (wbRfWdata)
	);

	always #20 clk = ~clk;

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic reportMismatch(input string name, input logic [`XLEN-1:0] got,
			input logic [`XLEN-1:0] want);
		stopWithFailure($sformatf("Error at %0t ns: %s got %h expected %h",
			$time, name, got, want));
	endtask

	task automatic checkWb(input mipsPkg::wbBusT got, input logic [`XLEN-1:0] gotPc,
			input mipsPkg::wbBusT want, input logic [`XLEN-1:0] wantPc);
		if (gotPc !== wantPc) reportMismatch("debugWbPc_o", gotPc, wantPc);
		if (got.we !== want.we) reportMismatch("debugWbRfWen_o", got.we, want.we);
		if (got.dest !== want.dest) reportMismatch("debugWbRfWnum_o", got.dest, want.dest);
		if (got.data !== want.data) reportMismatch("debugWbRfWdata_o", got.data, want.data);
	endtask

	task automatic checkMemWord(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] got,
			input logic [`XLEN-1:0] want);
		if (got !== want) begin
			stopWithFailure($sformatf("Error at %0t ns: data word %h got %h expected %h",
				$time, addr, got, want));
		end
	endtask

	// an all-zero word decodes as sll $0, a nop
	function automatic logic [`XLEN-1:0] fetchWord(input logic [`XLEN-1:0] addr);
		if (addr[31:8] == 24'h1fc000) return rom[addr[7:2]];
		return '0;
	endfunction

	function automatic logic [`XLEN-1:0] readData(input logic [`XLEN-1:0] addr);
		if (addr[31:8] == 24'h000001) return ram[addr[7:2]];
		return '0;
	endfunction

	task automatic writeData(input logic [`XLEN-1:0] addr, input logic [3:0] wen,
			input logic [`XLEN-1:0] wdata);
		logic [`XLEN-1:0] word;
		if (addr[31:8] != 24'h000001) begin
			stopWithFailure($sformatf("a store went to address %h outside the data RAM", addr));
		end
		word = ram[addr[7:2]];
		for (int lane = 0; lane < 4; lane++) begin
			if (wen[lane]) word[8*lane +: 8] = wdata[8*lane +: 8];
		end
		ram[addr[7:2]] = word;
	endtask

	task automatic loadCases();
		int                   fd;
		int                   n;
		logic [7:0]           tag;
		logic [`XLEN-1:0]     a;
		logic [`XLEN-1:0]     b;
		logic [`XLEN-1:0]     c;
		logic [8*160-1:0]     skipLine;
		mipsPkg::wbBusT       rec;
		for (int i = 0; i < 64; i++) begin
			rom[i] = '0;
			ram[i] = ~(32'h100 + 32'(i * 4)); // each unloaded word holds its own inverted address
		end
		fd = $fopen("coreCases.txt", "r");
		if (fd == 0) stopWithFailure("could not open coreCases.txt for reading");
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", tag);
			if (n == 1) begin
				case (tag)
					"#": n = $fgets(skipLine, fd);
					"P": begin
						n = $fscanf(fd, "%h %h", a, b);
						if (a[31:8] != 24'h1fc000) stopWithFailure("a program word lies outside the ROM");
						rom[a[7:2]] = b;
					end
					"D": begin
						n = $fscanf(fd, "%h %h", a, b);
						if (a[31:8] != 24'h000001) stopWithFailure("a data word lies outside the RAM");
						ram[a[7:2]] = b;
					end
					"W": begin
						n = $fscanf(fd, "%h %h %h", a, b, c);
						rec.we = 1'b1;
						rec.dest = b[`REG_AW-1:0];
						rec.data = c;
						expPc.push_back(a);
						expWb.push_back(rec);
					end
					"M": begin
						n = $fscanf(fd, "%h %h", a, b);
						chkAddr.push_back(a);
						chkData.push_back(b);
					end
					default: stopWithFailure("coreCases.txt holds a line of unknown kind");
				endcase
			end
		end
		$fclose(fd);
	endtask

	task automatic recordRetirement();
		mipsPkg::wbBusT got;
		got.we = (wbRfWen == 4'hf);
		got.dest = wbRfWnum;
		got.data = wbRfWdata;
		if (wbIdx >= expWb.size()) begin
			stopWithFailure($sformatf("an unexpected register write retired at pc %h", wbPc));
		end
		checkWb(got, wbPc, expWb[wbIdx], expPc[wbIdx]);
		wbIdx++;
	endtask

	// the pipeline needs four cycles before the first instruction reaches writeback
	task automatic checkResetState();
		for (int cycle = 0; cycle < 4; cycle++) begin
			@(negedge clk);
			if (cycle == 0 && instAddr !== (`RESET_PC & `PHYS_MASK)) begin
				reportMismatch("instAddr_o", instAddr, `RESET_PC & `PHYS_MASK);
			end
			if (wbRfWen !== 4'h0) reportMismatch("debugWbRfWen_o", wbRfWen, 4'h0);
			if (dataWen !== 4'h0) reportMismatch("dataWen_o", dataWen, 4'h0);
		end
	endtask

	task automatic waitForRetirement();
		int idle;
		int lastIdx;
		idle = 0;
		lastIdx = wbIdx;
		while (wbIdx < expWb.size()) begin
			@(posedge clk);
			idle = (wbIdx == lastIdx) ? idle + 1 : 0;
			lastIdx = wbIdx;
			if (idle >= 2000) begin
				stopWithFailure($sformatf("retirement stalled after %0d of %0d writeback records",
					wbIdx, expWb.size()));
			end
		end
	endtask

	task automatic checkFinalMemory();
		for (int i = 0; i < chkAddr.size(); i++) begin
			checkMemWord(chkAddr[i], readData(chkAddr[i]), chkData[i]);
		end
	endtask

	always @(negedge clk) begin
		instAddrQ = instAddr;
		dataAddrQ = dataAddr;
		dataWdataQ = dataWdata;
		dataWenQ = rstN ? dataWen : 4'h0;
		if (rstN && wbRfWen != 4'h0) recordRetirement();
	end

	// both SRAMs answer one cycle after the address they saw
	always @(posedge clk) begin
		#1;
		if (dataWenQ != 4'h0) writeData(dataAddrQ, dataWenQ, dataWdataQ);
		instRdata = fetchWord(instAddrQ);
		dataRdata = readData(dataAddrQ);
	end

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		instRdata = '0;
		dataRdata = '0;
		dataWenQ = 4'h0;
		wbIdx = 0;
		loadCases();
		repeat (3) @(posedge clk);
		#1;
		rstN = 1'b1;
		checkResetState();
		waitForRetirement();
		repeat (20) @(posedge clk); // the final loop must not retire any further write
		checkFinalMemory();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: coreCases.txt
# P addr word places a program word and D addr word an initial data word, at physical addresses
# W pc reg value is a writeback record in retirement order, M addr word an expected final data word
P 1fc00000 3c018000
P 1fc00004 34021234
P 1fc00008 2443fffc
P 1fc0000c 00622023
P 1fc00010 0082282a
P 1fc00014 0082302b
P 1fc00018 00433826
P 1fc0001c 00024100
P 1fc00020 00044f02
P 1fc00024 8c2a0100
P 1fc00028 01495821
P 1fc0002c 802c0101
P 1fc00030 902d0101
P 1fc00034 318eff0f
P 1fc00038 ac2b0104
P 1fc0003c a02d010b
P 1fc00040 288ffffd
P 1fc00044 10af0003
P 1fc00048 24100055
P 1fc0004c 24110066
P 1fc00054 14a60003
P 1fc00058 34120099
P 1fc0005c 24110066
P 1fc00064 0ff00020
P 1fc00068 24130011
P 1fc0006c 8c340104
P 1fc00070 02940021
P 1fc00074 0bf00024
P 1fc00078 24170023
P 1fc0007c 24110066
P 1fc00080 24150021
P 1fc00084 03e00008
P 1fc00088 24160022
P 1fc0008c 24110066
P 1fc00090 0bf00024
D 00000100 8899aabb
D 00000104 deadbeef
D 00000108 11223344
W bfc00000 01 80000000
W bfc00004 02 00001234
W bfc00008 03 00001230
W bfc0000c 04 fffffffc
W bfc00010 05 00000001
W bfc00014 06 00000000
W bfc00018 07 00000004
W bfc0001c 08 00012340
W bfc00020 09 0000000f
W bfc00024 0a 8899aabb
W bfc00028 0b 8899aaca
W bfc0002c 0c ffffffaa
W bfc00030 0d 000000aa
W bfc00034 0e 0000ff0a
W bfc00040 0f 00000001
W bfc00048 10 00000055
W bfc00058 12 00000099
W bfc00064 1f bfc0006c
W bfc00068 13 00000011
W bfc00080 15 00000021
W bfc00088 16 00000022
W bfc0006c 14 8899aaca
W bfc00078 17 00000023
M 00000100 8899aabb
M 00000104 8899aaca
M 00000108 aa223344

// File: src.f
+incdir+.
mipsPkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardCtrl.sv
mipsCore.sv
tbMipsCore.sv

// File: Bender.yml
package:
  name: mipsCore

sources:
  - include_dirs:
      - .
    files:
      - mipsPkg.sv
      - fetchStage.sv
      - decodeStage.sv
      - executeStage.sv
      - memoryStage.sv
      - hazardCtrl.sv
      - mipsCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbMipsCore.sv
